// ==== hdl/rv_params.svh ====
/* widths, CSR addresses and trap constants for the RV64 execute stage
   only the machine CSRs listed here are implemented */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define XLEN 64

// machine CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// implemented bit positions
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MIE_MTIE_BIT     7

// mcause values, interrupt flag in the top bit
`define CAUSE_ECALL_M 64'h0000_0000_0000_000b
`define CAUSE_MTIMER  64'h8000_0000_0000_0007

`define INTR_NO_TIMER 32'd7

// trap sequencer lengths in cycles
`define TRAP_STEPS_ENTER 4
`define TRAP_STEPS_RET   2

`endif

// ==== hdl/rv_pkg.sv ====
/* types shared by the execute stage, its units and the testbench
   operands arrive already resolved by the decoder */
`include "rv_params.svh"

package rv_pkg;

  typedef enum logic [7:0] {
    OP_NOP   = 8'd0,
    OP_ADD   = 8'd1,
    OP_SUB   = 8'd2,
    OP_AND   = 8'd3,
    OP_OR    = 8'd4,
    OP_XOR   = 8'd5,
    OP_SLL   = 8'd6,
    OP_SLT   = 8'd7,
    OP_BEQ   = 8'd8,
    OP_BNE   = 8'd9,
    OP_JAL   = 8'd10,
    OP_CSRRW = 8'd11,
    OP_CSRRS = 8'd12,
    OP_ECALL = 8'd13,
    OP_MRET  = 8'd14
  } rv_op_e;

  typedef enum logic [1:0] {
    TRAP_ECALL = 2'd0,
    TRAP_MRET  = 2'd1,
    TRAP_TIMER = 2'd2
  } trap_kind_e;

  // op3 carries the branch offset or the CSR address in bits 11:0
  typedef struct packed {
    rv_op_e             opcode;
    logic [`XLEN-1:0]   pc;
    logic [31:0]        inst;
    logic [`XLEN-1:0]   op1;
    logic [`XLEN-1:0]   op2;
    logic [`XLEN-1:0]   op3;
    logic [4:0]         rd;
    logic               rd_wen;
  } dec_pkt_t;

  typedef struct packed {
    logic [11:0]        addr;
    logic               ren;
    logic               wen;
    logic [`XLEN-1:0]   wdata;
  } csr_req_t;

  typedef struct packed {
    logic [`XLEN-1:0]   rd_wdata;
    logic               pc_jmp;
    logic [`XLEN-1:0]   jmp_addr;
  } unit_res_t;

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [4:0]         rd;
    logic               rd_wen;
    logic [`XLEN-1:0]   rd_wdata;
    logic               pc_jmp;
    logic [`XLEN-1:0]   jmp_addr;
    logic [31:0]        intr_no;
  } exe_res_t;

endpackage

// ==== hdl/exe_alu_unit.sv ====
/* single-cycle arithmetic, branch and CSR unit, purely combinational
   CSR read data must come back in the same cycle as the request */
`timescale 1ns/1ps
`include "rv_params.svh"

module exe_alu_unit (
  input  logic              i_ena,
  input  rv_pkg::dec_pkt_t  i_pkt,
  input  logic [`XLEN-1:0]  i_csr_rdata,
  output rv_pkg::csr_req_t  o_csr,
  output rv_pkg::unit_res_t o_res
);
  import rv_pkg::*;

  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] link;
  logic             lt;

  assign target = i_pkt.pc + i_pkt.op3;
  assign link   = i_pkt.pc + `XLEN'd4;
  assign lt     = $signed(i_pkt.op1) < $signed(i_pkt.op2);

  always_comb begin
    o_csr = '0;
    o_res = '0;
    if (i_ena) begin
      case (i_pkt.opcode)
        OP_ADD: o_res.rd_wdata = i_pkt.op1 + i_pkt.op2;
        OP_SUB: o_res.rd_wdata = i_pkt.op1 - i_pkt.op2;
        OP_AND: o_res.rd_wdata = i_pkt.op1 & i_pkt.op2;
        OP_OR:  o_res.rd_wdata = i_pkt.op1 | i_pkt.op2;
        OP_XOR: o_res.rd_wdata = i_pkt.op1 ^ i_pkt.op2;
        // rv64 shifts use six bits of shamt
        OP_SLL: o_res.rd_wdata = i_pkt.op1 << i_pkt.op2[5:0];
        OP_SLT: o_res.rd_wdata = {{(`XLEN-1){1'b0}}, lt};
        OP_BEQ: begin
          o_res.pc_jmp   = (i_pkt.op1 == i_pkt.op2);
          o_res.jmp_addr = target;
        end
        OP_BNE: begin
          o_res.pc_jmp   = (i_pkt.op1 != i_pkt.op2);
          o_res.jmp_addr = target;
        end
        OP_JAL: begin
          o_res.rd_wdata = link;
          o_res.pc_jmp   = 1'b1;
          o_res.jmp_addr = target;
        end
        OP_CSRRW: begin
          o_csr.addr     = i_pkt.op3[11:0];
          o_csr.ren      = 1'b1;
          o_csr.wen      = 1'b1;
          o_csr.wdata    = i_pkt.op1;
          o_res.rd_wdata = i_csr_rdata;
        end
        OP_CSRRS: begin
          o_csr.addr     = i_pkt.op3[11:0];
          o_csr.ren      = 1'b1;
          // a zero mask is a pure read
          o_csr.wen      = (i_pkt.op1 != '0);
          o_csr.wdata    = i_csr_rdata | i_pkt.op1;
          o_res.rd_wdata = i_csr_rdata;
        end
        default: begin
          o_csr = '0;
          o_res = '0;
        end
      endcase
    end
  end

endmodule

// ==== hdl/exe_trap_unit.sv ====
/* trap sequencer for ECALL, MRET and the machine timer interrupt
   i_start is a one-cycle pulse and must not arrive while a sequence runs */
`timescale 1ns/1ps
`include "rv_params.svh"

module exe_trap_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_start,
  input  rv_pkg::trap_kind_e  i_kind,
  input  logic [`XLEN-1:0]    i_pc,
  input  logic [`XLEN-1:0]    i_csr_rdata,
  output rv_pkg::csr_req_t    o_csr,
  output logic                o_done,
  output rv_pkg::unit_res_t   o_res
);
  import rv_pkg::*;

  localparam int STEP_W = $clog2(`TRAP_STEPS_ENTER);

  logic              busy;
  logic [STEP_W-1:0] step;
  logic [STEP_W-1:0] last_step;
  trap_kind_e        kind;
  logic [`XLEN-1:0]  epc;
  logic [`XLEN-1:0]  jmp_addr;
  logic              is_ret;
  logic              at_last;

  assign is_ret    = (kind == TRAP_MRET);
  assign last_step = is_ret ? STEP_W'(`TRAP_STEPS_RET - 1) : STEP_W'(`TRAP_STEPS_ENTER - 1);
  assign at_last   = busy && (step == last_step);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      step   <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (at_last) begin
        busy   <= 1'b0;
        o_done <= 1'b1;
      end else if (busy) begin
        step <= step + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      kind <= i_kind;
      epc  <= i_pc;
    end
    // last step always reads mtvec or mepc
    if (at_last) begin
      jmp_addr <= i_csr_rdata;
    end
  end

  always_comb begin
    o_csr = '0;
    if (busy) begin
      if (is_ret) begin
        case (step)
          0: begin
            o_csr.addr  = `CSR_MSTATUS;
            o_csr.ren   = 1'b1;
            o_csr.wen   = 1'b1;
            o_csr.wdata = i_csr_rdata;
            o_csr.wdata[`MSTATUS_MIE_BIT] = i_csr_rdata[`MSTATUS_MPIE_BIT];
          end
          default: begin
            o_csr.addr = `CSR_MEPC;
            o_csr.ren  = 1'b1;
          end
        endcase
      end else begin
        case (step)
          0: begin
            o_csr.addr  = `CSR_MEPC;
            o_csr.wen   = 1'b1;
            o_csr.wdata = epc;
          end
          1: begin
            o_csr.addr  = `CSR_MCAUSE;
            o_csr.wen   = 1'b1;
            o_csr.wdata = (kind == TRAP_TIMER) ? `CAUSE_MTIMER : `CAUSE_ECALL_M;
          end
          2: begin
            o_csr.addr  = `CSR_MSTATUS;
            o_csr.ren   = 1'b1;
            o_csr.wen   = 1'b1;
            o_csr.wdata = i_csr_rdata;
            o_csr.wdata[`MSTATUS_MPIE_BIT] = i_csr_rdata[`MSTATUS_MIE_BIT];
            o_csr.wdata[`MSTATUS_MIE_BIT]  = 1'b0;
          end
          default: begin
            o_csr.addr = `CSR_MTVEC;
            o_csr.ren  = 1'b1;
          end
        endcase
      end
    end
  end

  assign o_res.rd_wdata = '0;
  assign o_res.pc_jmp   = o_done;
  assign o_res.jmp_addr = jmp_addr;

  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    i_start |-> !busy && !o_done)
    else $error("trap unit started while busy");

endmodule

// ==== hdl/exe_dispatch.sv ====
/* execute stage front end with four-phase handshakes on both sides
   one instruction in flight, the timer interrupt is sampled at capture */
`timescale 1ns/1ps
`include "rv_params.svh"

module exe_dispatch (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_dec_req,
  output logic                o_dec_ack,
  input  rv_pkg::dec_pkt_t    i_dec_pkt,
  output logic                o_exe_req,
  input  logic                i_exe_ack,
  output rv_pkg::exe_res_t    o_exe_res,
  input  logic                i_mtime_overflow,
  input  logic                i_mstatus_mie,
  input  logic                i_mie_mtie,
  output logic                o_alu_ena,
  output rv_pkg::dec_pkt_t    o_alu_pkt,
  input  rv_pkg::csr_req_t    i_alu_csr,
  input  rv_pkg::unit_res_t   i_alu_res,
  output logic                o_trap_start,
  output rv_pkg::trap_kind_e  o_trap_kind,
  output logic [`XLEN-1:0]    o_trap_pc,
  input  rv_pkg::csr_req_t    i_trap_csr,
  input  logic                i_trap_done,
  input  rv_pkg::unit_res_t   i_trap_res,
  output rv_pkg::csr_req_t    o_csr
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_EXEC,
    S_OUT,
    S_DRAIN
  } state_e;

  state_e    state;
  dec_pkt_t  cur_pkt;
  logic      cur_intr;
  logic      intr_req;
  logic      is_trap_op;
  logic      accept;
  logic      unit_done;
  unit_res_t unit_res;
  exe_res_t  res;

  assign intr_req   = i_mstatus_mie & i_mie_mtie & i_mtime_overflow;
  assign is_trap_op = (i_dec_pkt.opcode == OP_ECALL) || (i_dec_pkt.opcode == OP_MRET);
  assign accept     = (state == S_IDLE) && !o_dec_ack && i_dec_req;
  // alu finishes in its single enabled cycle
  assign unit_done  = (state == S_EXEC) && (o_alu_ena || i_trap_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      o_dec_ack    <= 1'b0;
      o_exe_req    <= 1'b0;
      o_alu_ena    <= 1'b0;
      o_trap_start <= 1'b0;
    end else begin
      o_trap_start <= 1'b0;
      if (accept) begin
        o_dec_ack <= 1'b1;
      end else if (o_dec_ack && !i_dec_req) begin
        o_dec_ack <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (accept) begin
            state <= S_EXEC;
            if (intr_req || is_trap_op) begin
              o_trap_start <= 1'b1;
            end else begin
              o_alu_ena <= 1'b1;
            end
          end
        end
        S_EXEC: begin
          if (unit_done) begin
            o_alu_ena <= 1'b0;
            o_exe_req <= 1'b1;
            state     <= S_OUT;
          end
        end
        S_OUT: begin
          if (i_exe_ack) begin
            o_exe_req <= 1'b0;
            state     <= S_DRAIN;
          end
        end
        default: begin
          if (!i_exe_ack) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cur_pkt  <= i_dec_pkt;
      cur_intr <= intr_req;
      if (intr_req) begin
        o_trap_kind <= TRAP_TIMER;
      end else if (i_dec_pkt.opcode == OP_MRET) begin
        o_trap_kind <= TRAP_MRET;
      end else begin
        o_trap_kind <= TRAP_ECALL;
      end
    end
    if (unit_done) begin
      o_exe_res <= res;
    end
  end

  assign unit_res = o_alu_ena ? i_alu_res : i_trap_res;

  // trap paths never write rd
  assign res.pc       = cur_pkt.pc;
  assign res.rd       = cur_pkt.rd;
  assign res.rd_wen   = o_alu_ena & cur_pkt.rd_wen;
  assign res.rd_wdata = unit_res.rd_wdata;
  assign res.pc_jmp   = unit_res.pc_jmp;
  assign res.jmp_addr = unit_res.jmp_addr;
  assign res.intr_no  = cur_intr ? `INTR_NO_TIMER : 32'd0;

  assign o_alu_pkt = cur_pkt;
  assign o_trap_pc = cur_pkt.pc;
  assign o_csr     = o_alu_ena ? i_alu_csr : i_trap_csr;

  a_exe_hold: assert property (@(posedge clk) disable iff (rst)
    o_exe_req && !i_exe_ack |=> o_exe_req && $stable(o_exe_res))
    else $error("exe result dropped or changed before ack");

  a_csr_one_owner: assert property (@(posedge clk) disable iff (rst)
    !((i_alu_csr.ren || i_alu_csr.wen) && (i_trap_csr.ren || i_trap_csr.wen)))
    else $error("both units access the CSR file in one cycle");

endmodule

// ==== hdl/csr_machine.sv ====
/* machine CSR file with mstatus, mie, mtvec, mepc and mcause only
   mstatus keeps MIE and MPIE, mie keeps MTIE, other bits read as zero */
`timescale 1ns/1ps
`include "rv_params.svh"

module csr_machine (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::csr_req_t    i_csr,
  output logic [`XLEN-1:0]    o_rdata,
  output logic                o_mstatus_mie,
  output logic                o_mie_mtie
);
  import rv_pkg::*;

  logic             mstatus_mie;
  logic             mstatus_mpie;
  logic             mie_mtie;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mie_mtie     <= 1'b0;
      mtvec        <= '0;
      mepc         <= '0;
      mcause       <= '0;
    end else if (i_csr.wen) begin
      case (i_csr.addr)
        `CSR_MSTATUS: begin
          mstatus_mie  <= i_csr.wdata[`MSTATUS_MIE_BIT];
          mstatus_mpie <= i_csr.wdata[`MSTATUS_MPIE_BIT];
        end
        `CSR_MIE:    mie_mtie <= i_csr.wdata[`MIE_MTIE_BIT];
        // direct mode only, 4-byte aligned
        `CSR_MTVEC:  mtvec  <= {i_csr.wdata[`XLEN-1:2], 2'b00};
        `CSR_MEPC:   mepc   <= {i_csr.wdata[`XLEN-1:2], 2'b00};
        `CSR_MCAUSE: mcause <= i_csr.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    o_rdata = '0;
    if (i_csr.ren) begin
      case (i_csr.addr)
        `CSR_MSTATUS: begin
          o_rdata[`MSTATUS_MIE_BIT]  = mstatus_mie;
          o_rdata[`MSTATUS_MPIE_BIT] = mstatus_mpie;
        end
        `CSR_MIE:    o_rdata[`MIE_MTIE_BIT] = mie_mtie;
        `CSR_MTVEC:  o_rdata = mtvec;
        `CSR_MEPC:   o_rdata = mepc;
        `CSR_MCAUSE: o_rdata = mcause;
        default:     o_rdata = '0;
      endcase
    end
  end

  assign o_mstatus_mie = mstatus_mie;
  assign o_mie_mtie    = mie_mtie;

endmodule

// ==== hdl/exe_top.sv ====
/* execute stage top, dispatcher with ALU and trap units and the CSR file
   mtime overflow comes from an external timer */
`timescale 1ns/1ps
`include "rv_params.svh"

module exe_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_dec_req,
  output logic              o_dec_ack,
  input  rv_pkg::dec_pkt_t  i_dec_pkt,
  output logic              o_exe_req,
  input  logic              i_exe_ack,
  output rv_pkg::exe_res_t  o_exe_res,
  input  logic              i_mtime_overflow
);
  import rv_pkg::*;

  logic             alu_ena;
  dec_pkt_t         alu_pkt;
  csr_req_t         alu_csr;
  unit_res_t        alu_res;
  logic             trap_start;
  trap_kind_e       trap_kind;
  logic [`XLEN-1:0] trap_pc;
  csr_req_t         trap_csr;
  logic             trap_done;
  unit_res_t        trap_res;
  csr_req_t         csr;
  logic [`XLEN-1:0] csr_rdata;
  logic             mstatus_mie;
  logic             mie_mtie;

  exe_dispatch i_dispatch (
    .clk              (clk),
    .rst              (rst),
    .i_dec_req        (i_dec_req),
    .o_dec_ack        (o_dec_ack),
    .i_dec_pkt        (i_dec_pkt),
    .o_exe_req        (o_exe_req),
    .i_exe_ack        (i_exe_ack),
    .o_exe_res        (o_exe_res),
    .i_mtime_overflow (i_mtime_overflow),
    .i_mstatus_mie    (mstatus_mie),
    .i_mie_mtie       (mie_mtie),
    .o_alu_ena        (alu_ena),
    .o_alu_pkt        (alu_pkt),
    .i_alu_csr        (alu_csr),
    .i_alu_res        (alu_res),
    .o_trap_start     (trap_start),
    .o_trap_kind      (trap_kind),
    .o_trap_pc        (trap_pc),
    .i_trap_csr       (trap_csr),
    .i_trap_done      (trap_done),
    .i_trap_res       (trap_res),
    .o_csr            (csr)
  );

  exe_alu_unit i_alu (
    .i_ena       (alu_ena),
    .i_pkt       (alu_pkt),
    .i_csr_rdata (csr_rdata),
    .o_csr       (alu_csr),
    .o_res       (alu_res)
  );

  exe_trap_unit i_trap (
    .clk         (clk),
    .rst         (rst),
    .i_start     (trap_start),
    .i_kind      (trap_kind),
    .i_pc        (trap_pc),
    .i_csr_rdata (csr_rdata),
    .o_csr       (trap_csr),
    .o_done      (trap_done),
    .o_res       (trap_res)
  );

  csr_machine i_csr (
    .clk           (clk),
    .rst           (rst),
    .i_csr         (csr),
    .o_rdata       (csr_rdata),
    .o_mstatus_mie (mstatus_mie),
    .o_mie_mtie    (mie_mtie)
  );

endmodule

// ==== tests/exe_tb.sv ====
/* execute stage testbench, results are checked against a reference model
   operands and ack delays come from a seeded LCG, the run ends at a cycle limit */
`timescale 1ns/1ps
`include "rv_params.svh"

module exe_tb;
  import rv_pkg::*;

  localparam int N_ALU    = 40;
  localparam int N_BRANCH = 6;
  localparam int N_CSR    = 7;
  localparam int N_ECALL  = 4;
  localparam int N_TIMER  = 8;
  localparam int N_BP     = 30;
  localparam int N_INSTR  = N_ALU + N_BRANCH + N_CSR + N_ECALL + N_TIMER + N_BP;
  localparam int TIMEOUT_CYCLES = 40 * N_INSTR + 100;

  logic             clk;
  logic             rst;
  logic             i_dec_req;
  logic             o_dec_ack;
  dec_pkt_t         i_dec_pkt;
  logic             o_exe_req;
  logic             i_exe_ack;
  exe_res_t         o_exe_res;
  logic             i_mtime_overflow;

  exe_res_t         exp_q[$];
  exe_res_t         exp_cur;
  logic             req_seen;
  logic             handshake;
  int               errors = 0;
  int               orphans = 0;
  int               n_tests = 0;
  int               n_issued = 0;
  int               n_results = 0;
  int               cycles = 0;
  logic [31:0]      stim_state = 32'd82;
  logic [31:0]      ack_state = 32'd82;
  logic [`XLEN-1:0] pc_cur;

  // mirror of the machine CSRs
  logic             m_mie;
  logic             m_mpie;
  logic             m_mtie;
  logic [`XLEN-1:0] m_mtvec;
  logic [`XLEN-1:0] m_mepc;
  logic [`XLEN-1:0] m_mcause;

  exe_top i_exe_top (
    .clk              (clk),
    .rst              (rst),
    .i_dec_req        (i_dec_req),
    .o_dec_ack        (o_dec_ack),
    .i_dec_pkt        (i_dec_pkt),
    .o_exe_req        (o_exe_req),
    .i_exe_ack        (i_exe_ack),
    .o_exe_res        (o_exe_res),
    .i_mtime_overflow (i_mtime_overflow)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1103515245 + 32'd12345;
    return state;
  endfunction

  function automatic logic [`XLEN-1:0] draw_word();
    return {lcg_next(stim_state), lcg_next(stim_state)};
  endfunction

  function automatic int error_total();
    return errors + orphans;
  endfunction

  function automatic dec_pkt_t build_pkt(input rv_op_e op, input logic [`XLEN-1:0] op1,
                                         input logic [`XLEN-1:0] op2,
                                         input logic [`XLEN-1:0] op3,
                                         input logic [4:0] rd, input logic rd_wen);
    dec_pkt_t p;
    p.opcode = op;
    p.pc     = pc_cur;
    p.inst   = 32'h0;
    p.op1    = op1;
    p.op2    = op2;
    p.op3    = op3;
    p.rd     = rd;
    p.rd_wen = rd_wen;
    return p;
  endfunction

  function automatic dec_pkt_t pick_alu_pkt();
    logic [31:0] r;
    int          sel;
    rv_op_e      op;
    r   = lcg_next(stim_state);
    sel = int'(r >> 16) % 7;
    case (sel)
      0:       op = OP_ADD;
      1:       op = OP_SUB;
      2:       op = OP_AND;
      3:       op = OP_OR;
      4:       op = OP_XOR;
      5:       op = OP_SLL;
      default: op = OP_SLT;
    endcase
    return build_pkt(op, draw_word(), draw_word(), '0,
                     (r[27:23] == 5'd0) ? 5'd1 : r[27:23], 1'b1);
  endfunction

  function automatic logic [`XLEN-1:0] read_csr_mirror(input logic [11:0] addr);
    logic [`XLEN-1:0] v;
    v = '0;
    case (addr)
      `CSR_MSTATUS: begin
        v[`MSTATUS_MIE_BIT]  = m_mie;
        v[`MSTATUS_MPIE_BIT] = m_mpie;
      end
      `CSR_MIE:    v[`MIE_MTIE_BIT] = m_mtie;
      `CSR_MTVEC:  v = m_mtvec;
      `CSR_MEPC:   v = m_mepc;
      `CSR_MCAUSE: v = m_mcause;
      default:     v = '0;
    endcase
    return v;
  endfunction

  function automatic void write_csr_mirror(input logic [11:0] addr,
                                           input logic [`XLEN-1:0] data);
    case (addr)
      `CSR_MSTATUS: begin
        m_mie  = data[`MSTATUS_MIE_BIT];
        m_mpie = data[`MSTATUS_MPIE_BIT];
      end
      `CSR_MIE:    m_mtie   = data[`MIE_MTIE_BIT];
      `CSR_MTVEC:  m_mtvec  = {data[`XLEN-1:2], 2'b00};
      `CSR_MEPC:   m_mepc   = {data[`XLEN-1:2], 2'b00};
      `CSR_MCAUSE: m_mcause = data;
      default: ;
    endcase
  endfunction

  function automatic void enter_trap(input logic [`XLEN-1:0] pc,
                                     input logic [`XLEN-1:0] cause);
    m_mepc   = {pc[`XLEN-1:2], 2'b00};
    m_mcause = cause;
    m_mpie   = m_mie;
    m_mie    = 1'b0;
  endfunction

  // expected result, updates the CSR mirror as a side effect
  function automatic exe_res_t predict_result(input dec_pkt_t p, input logic irq);
    exe_res_t         r;
    logic [`XLEN-1:0] old;
    logic [11:0]      a;
    r        = '0;
    r.pc     = p.pc;
    r.rd     = p.rd;
    r.rd_wen = p.rd_wen;
    a        = p.op3[11:0];
    if (irq && m_mie && m_mtie) begin
      enter_trap(p.pc, `CAUSE_MTIMER);
      r.rd_wen   = 1'b0;
      r.intr_no  = `INTR_NO_TIMER;
      r.pc_jmp   = 1'b1;
      r.jmp_addr = m_mtvec;
    end else begin
      case (p.opcode)
        OP_ADD: r.rd_wdata = p.op1 + p.op2;
        OP_SUB: r.rd_wdata = p.op1 - p.op2;
        OP_AND: r.rd_wdata = p.op1 & p.op2;
        OP_OR:  r.rd_wdata = p.op1 | p.op2;
        OP_XOR: r.rd_wdata = p.op1 ^ p.op2;
        OP_SLL: r.rd_wdata = p.op1 << p.op2[5:0];
        OP_SLT: r.rd_wdata = {{(`XLEN-1){1'b0}}, ($signed(p.op1) < $signed(p.op2))};
        OP_BEQ: begin
          r.pc_jmp   = (p.op1 == p.op2);
          r.jmp_addr = p.pc + p.op3;
        end
        OP_BNE: begin
          r.pc_jmp   = (p.op1 != p.op2);
          r.jmp_addr = p.pc + p.op3;
        end
        OP_JAL: begin
          r.rd_wdata = p.pc + `XLEN'd4;
          r.pc_jmp   = 1'b1;
          r.jmp_addr = p.pc + p.op3;
        end
        OP_CSRRW: begin
          old = read_csr_mirror(a);
          write_csr_mirror(a, p.op1);
          r.rd_wdata = old;
        end
        OP_CSRRS: begin
          old = read_csr_mirror(a);
          if (p.op1 != '0) begin
            write_csr_mirror(a, old | p.op1);
          end
          r.rd_wdata = old;
        end
        OP_ECALL: begin
          enter_trap(p.pc, `CAUSE_ECALL_M);
          r.rd_wen   = 1'b0;
          r.pc_jmp   = 1'b1;
          r.jmp_addr = m_mtvec;
        end
        OP_MRET: begin
          m_mie      = m_mpie;
          r.rd_wen   = 1'b0;
          r.pc_jmp   = 1'b1;
          r.jmp_addr = m_mepc;
        end
        default: ;
      endcase
    end
    return r;
  endfunction

  // four-phase upstream handshake, irq rides along until ack
  task automatic issue_instr(input dec_pkt_t p, input logic irq);
    exp_q.push_back(predict_result(p, irq));
    n_issued++;
    pc_cur = pc_cur + `XLEN'd4;
    @(posedge clk);
    i_dec_req        <= 1'b1;
    i_dec_pkt        <= p;
    i_mtime_overflow <= irq;
    do @(posedge clk); while (!o_dec_ack);
    i_dec_req        <= 1'b0;
    i_mtime_overflow <= 1'b0;
    do @(posedge clk); while (o_dec_ack);
  endtask

  task automatic access_csr(input rv_op_e op, input logic [11:0] addr,
                            input logic [`XLEN-1:0] data);
    issue_instr(build_pkt(op, data, '0, {52'h0, addr}, 5'd10, 1'b1), 1'b0);
  endtask

  task automatic wait_results();
    while (n_results != n_issued) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int err_mark);
    wait_results();
    n_tests++;
    $display("%s: %0d errors, %0d results so far", name, error_total() - err_mark,
             n_results);
  endtask

  // downstream side with random ack delay
  initial begin : ack_driver
    int delay;
    i_exe_ack = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst && o_exe_req && !i_exe_ack) begin
        delay = int'(lcg_next(ack_state) >> 30);
        repeat (delay) @(posedge clk);
        i_exe_ack <= 1'b1;
        do @(posedge clk); while (o_exe_req);
        i_exe_ack <= 1'b0;
      end
    end
  end

  assign handshake = o_exe_req && i_exe_ack;

  // expected value is taken when a result first shows up
  always @(posedge clk) begin
    if (rst) begin
      req_seen <= 1'b0;
    end else begin
      if (o_exe_req && !req_seen) begin
        req_seen <= 1'b1;
        if (exp_q.size() == 0) begin
          orphans++;
          $display("result came out with no instruction pending");
        end else begin
          exp_cur <= exp_q.pop_front();
        end
      end else if (!o_exe_req) begin
        req_seen <= 1'b0;
      end
      if (handshake) begin
        n_results <= n_results + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d results", cycles, n_results, n_issued);
      $display("test failed");
      $finish;
    end
  end

  a_pc: assert property (@(posedge clk) disable iff (rst)
    handshake |-> o_exe_res.pc == exp_cur.pc)
    else begin
      errors++;
      $display("Mismatch pc: got %h expected %h", o_exe_res.pc, exp_cur.pc);
    end

  a_rd: assert property (@(posedge clk) disable iff (rst)
    handshake |-> o_exe_res.rd == exp_cur.rd)
    else begin
      errors++;
      $display("Mismatch rd: got %h expected %h", o_exe_res.rd, exp_cur.rd);
    end

  a_rd_wen: assert property (@(posedge clk) disable iff (rst)
    handshake |-> o_exe_res.rd_wen == exp_cur.rd_wen)
    else begin
      errors++;
      $display("Mismatch rd_wen: got %h expected %h", o_exe_res.rd_wen, exp_cur.rd_wen);
    end

  a_rd_wdata: assert property (@(posedge clk) disable iff (rst)
    handshake && exp_cur.rd_wen |-> o_exe_res.rd_wdata == exp_cur.rd_wdata)
    else begin
      errors++;
      $display("Mismatch rd_wdata: got %h expected %h", o_exe_res.rd_wdata,
               exp_cur.rd_wdata);
    end

  a_pc_jmp: assert property (@(posedge clk) disable iff (rst)
    handshake |-> o_exe_res.pc_jmp == exp_cur.pc_jmp)
    else begin
      errors++;
      $display("Mismatch pc_jmp: got %h expected %h", o_exe_res.pc_jmp, exp_cur.pc_jmp);
    end

  a_jmp_addr: assert property (@(posedge clk) disable iff (rst)
    handshake && exp_cur.pc_jmp |-> o_exe_res.jmp_addr == exp_cur.jmp_addr)
    else begin
      errors++;
      $display("Mismatch jmp_addr: got %h expected %h", o_exe_res.jmp_addr,
               exp_cur.jmp_addr);
    end

  a_intr_no: assert property (@(posedge clk) disable iff (rst)
    handshake |-> o_exe_res.intr_no == exp_cur.intr_no)
    else begin
      errors++;
      $display("Mismatch intr_no: got %h expected %h", o_exe_res.intr_no, exp_cur.intr_no);
    end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    o_exe_req && !i_exe_ack |=> o_exe_req && $stable(o_exe_res))
    else begin
      errors++;
      $display("o_exe_req or o_exe_res changed before the ack came");
    end

  a_reset_idle: assert property (@(posedge clk)
    $past(rst) && !rst |-> !o_dec_ack && !o_exe_req)
    else begin
      errors++;
      $display("handshake outputs not low after reset");
    end

  initial begin : main
    int          err_mark;
    int          k;
    logic [31:0] r;
    clk              = 1'b0;
    rst              = 1'b1;
    i_dec_req        = 1'b0;
    i_dec_pkt        = '0;
    i_mtime_overflow = 1'b0;
    pc_cur           = 64'h0000_0000_8000_0000;
    m_mie            = 1'b0;
    m_mpie           = 1'b0;
    m_mtie           = 1'b0;
    m_mtvec          = '0;
    m_mepc           = '0;
    m_mcause         = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    err_mark = error_total();
    for (k = 0; k < N_ALU; k++) begin
      issue_instr(pick_alu_pkt(), 1'b0);
    end
    report_test("alu_random", err_mark);

    err_mark = error_total();
    issue_instr(build_pkt(OP_BEQ, 64'h1234, 64'h1234, 64'h40, 5'd0, 1'b0), 1'b0);
    issue_instr(build_pkt(OP_BEQ, 64'h1234, 64'h1235, 64'h40, 5'd0, 1'b0), 1'b0);
    issue_instr(build_pkt(OP_BNE, draw_word(), '0, 64'hffff_ffff_ffff_fff0, 5'd0, 1'b0),
                1'b0);
    issue_instr(build_pkt(OP_BNE, 64'h55, 64'h55, 64'h80, 5'd0, 1'b0), 1'b0);
    issue_instr(build_pkt(OP_JAL, '0, '0, 64'h100, 5'd1, 1'b1), 1'b0);
    issue_instr(build_pkt(OP_JAL, '0, '0, 64'hffff_ffff_ffff_ffe0, 5'd5, 1'b1), 1'b0);
    report_test("branch_jal", err_mark);

    err_mark = error_total();
    access_csr(OP_CSRRW, `CSR_MTVEC, 64'h0000_0000_8000_0103);
    access_csr(OP_CSRRS, `CSR_MTVEC, '0);
    access_csr(OP_CSRRW, `CSR_MIE, 64'hffff_ffff_ffff_ffff);
    access_csr(OP_CSRRS, `CSR_MIE, '0);
    access_csr(OP_CSRRW, `CSR_MIE, '0);
    // unimplemented address
    access_csr(OP_CSRRS, 12'h7c0, 64'h5);
    access_csr(OP_CSRRW, `CSR_MTVEC, 64'h0000_0000_8000_2000);
    report_test("csr_rw", err_mark);

    err_mark = error_total();
    pc_cur = 64'h0000_0000_8000_0400;
    issue_instr(build_pkt(OP_ECALL, '0, '0, '0, 5'd0, 1'b0), 1'b0);
    access_csr(OP_CSRRS, `CSR_MEPC, '0);
    access_csr(OP_CSRRS, `CSR_MCAUSE, '0);
    issue_instr(build_pkt(OP_MRET, '0, '0, '0, 5'd0, 1'b0), 1'b0);
    report_test("ecall_mret", err_mark);

    err_mark = error_total();
    access_csr(OP_CSRRS, `CSR_MSTATUS, 64'h8);
    access_csr(OP_CSRRS, `CSR_MIE, 64'h80);
    issue_instr(build_pkt(OP_ADD, draw_word(), draw_word(), '0, 5'd3, 1'b1), 1'b1);
    access_csr(OP_CSRRS, `CSR_MCAUSE, '0);
    access_csr(OP_CSRRS, `CSR_MEPC, '0);
    issue_instr(build_pkt(OP_MRET, '0, '0, '0, 5'd0, 1'b0), 1'b0);
    access_csr(OP_CSRRS, `CSR_MSTATUS, '0);
    access_csr(OP_CSRRW, `CSR_MIE, '0);
    report_test("timer_irq", err_mark);

    // upstream gaps on top of the random ack delays
    err_mark = error_total();
    for (k = 0; k < N_BP; k++) begin
      r = lcg_next(stim_state);
      repeat (r[31:30]) @(posedge clk);
      issue_instr(pick_alu_pkt(), 1'b0);
    end
    report_test("backpressure", err_mark);

    repeat (10) @(posedge clk);
    if (n_results != n_issued || exp_q.size() != 0) begin
      orphans++;
      $display("got %0d results for %0d instructions", n_results, n_issued);
    end
    $display("tests %0d, results %0d, errors %0d", n_tests, n_results, error_total());
    if (error_total() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/exe_alu_unit.sv
hdl/exe_trap_unit.sv
hdl/exe_dispatch.sv
hdl/csr_machine.sv
hdl/exe_top.sv
tests/exe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := exe_tb
RTL_TOP   := exe_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
